// File: verilog/vdp_bus_pkg.sv
// vdp bus package: bus words, download address views, section limits and command words
package vdp_bus_pkg;

	// one word on the shared VDP data bus
	typedef logic [15:0] bus_word_t;

	// one word of the downloaded image
	typedef logic [15:0] dl_data_t;

	// download word address, read per section
	typedef union packed {
		struct packed {
			logic        spare;
			logic [2:0]  page;
			logic [14:0] offset;
		} vram_view;
		struct packed {
			logic [3:0]  tag;
			logic [14:0] index;
		} tbl_view;
	} dl_addr_u;

	// which video processor a write goes to
	typedef enum logic {
		sel_vdp1 = 1'b0,
		sel_vdp2 = 1'b1
	} vdp_sel_e;

	////////////////////
	// section ends, as word addresses
	localparam logic [18:0] VRAM_LAST = 19'h3FFFF;
	localparam logic [18:0] REG_LAST  = 19'h400FF;
	localparam logic [18:0] PAL_LAST  = 19'h408FF;

	////////////////////
	// fixed words of the register and colour writes
	localparam bus_word_t   REG_HI   = 16'h0018;
	localparam bus_word_t   PAL_HI   = 16'h0010;
	localparam logic [14:0] PAL_BASE = 15'h0100;
	localparam bus_word_t   DISP_ON  = 16'h8000;

	// last count of the VDP reset phase, four cycles in all
	localparam logic [1:0] RST_CYCLES = 2'd3;

endpackage

// File: verilog/video_cfg_pkg.sv
// video config package: resolution codes, aspect ratio pairs and debug key codes
package video_cfg_pkg;

	// resolution code, {v30, h40}
	typedef enum logic [1:0] {
		res_256_224 = 2'b00,
		res_320_224 = 2'b01,
		res_256_240 = 2'b10,
		res_320_240 = 2'b11
	} res_e;

	// aspect pair, x ratio in the high byte and y ratio in the low byte
	typedef logic [15:0] aspect_t;

	////////////////////
	// aspect pairs
	localparam aspect_t AR_WIDE      = {8'd16, 8'd9};
	localparam aspect_t AR_256_224   = {8'd64, 8'd49};
	localparam aspect_t AR_320_224_C = {8'd10, 8'd7};
	localparam aspect_t AR_256_240   = {8'd128, 8'd105};
	localparam aspect_t AR_320_240_C = {8'd4, 8'd3};

	// key event: [10] toggle, [9] pressed, [8:0] scan code
	typedef logic [10:0] key_evt_t;

	////////////////////
	// function key scan codes
	localparam logic [8:0] KEY_F1 = 9'h005;
	localparam logic [8:0] KEY_F2 = 9'h006;
	localparam logic [8:0] KEY_F3 = 9'h004;
	localparam logic [8:0] KEY_F4 = 9'h00C;
	localparam logic [8:0] KEY_F5 = 9'h003;
	localparam logic [8:0] KEY_F6 = 9'h00B;

	// screen layers under debug control
	localparam int NUM_LAYERS = 6;

endpackage

// File: verilog/state_loader.sv
// save-state loader: sequences image sections and issues VDP bus write requests
module state_loader (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   dl_active,
	input  logic                   dl_index0,
	input  logic                   dl_wr,
	input  vdp_bus_pkg::dl_addr_u  dl_addr,
	input  vdp_bus_pkg::dl_data_t  dl_data,
	input  logic                   done,
	output logic                   dl_wait,
	output logic                   vdp_rst_n,
	output logic                   start,
	output vdp_bus_pkg::vdp_sel_e  target,
	output vdp_bus_pkg::bus_word_t hi_word,
	output vdp_bus_pkg::bus_word_t lo_word,
	output vdp_bus_pkg::bus_word_t data_word,
	output logic                   wait_rdy
);

	localparam logic [2:0] ST_IDLE      = 3'd0;
	localparam logic [2:0] ST_RESET     = 3'd1;
	localparam logic [2:0] ST_VDP1_VRAM = 3'd2;
	localparam logic [2:0] ST_VRAM      = 3'd3;
	localparam logic [2:0] ST_REG       = 3'd4;
	localparam logic [2:0] ST_PAL       = 3'd5;
	localparam logic [2:0] ST_DISP_ON   = 3'd6;
	localparam logic [2:0] ST_END       = 3'd7;

	logic [2:0]            state;
	logic [2:0]            sect_next;
	logic [18:0]           sect_last;
	logic [1:0]            rst_cnt;
	logic                  img_vdp1;
	logic                  busy;
	logic                  in_section;
	logic                  accept;
	logic [14:0]           pal_idx;
	vdp_bus_pkg::dl_addr_u req_addr;
	vdp_bus_pkg::dl_data_t req_data;

	assign in_section = (state == ST_VDP1_VRAM) || (state == ST_VRAM) ||
		(state == ST_REG) || (state == ST_PAL);
	assign accept = in_section && !busy && dl_wr;

	// colour RAM entries start past the register block
	assign pal_idx = req_addr.tbl_view.index - vdp_bus_pkg::PAL_BASE;

	// end address and successor of the current section
	always_comb begin
		sect_last = vdp_bus_pkg::VRAM_LAST;
		sect_next = ST_END;
		case (state)
			ST_VRAM: begin
				sect_next = ST_REG;
			end
			ST_REG: begin
				sect_last = vdp_bus_pkg::REG_LAST;
				sect_next = ST_PAL;
			end
			ST_PAL: begin
				sect_last = vdp_bus_pkg::PAL_LAST;
				sect_next = ST_DISP_ON;
			end
			default: begin
			end
		endcase
	end

	////////////////////
	// request fields
	always_comb begin
		target    = vdp_bus_pkg::sel_vdp2;
		hi_word   = '0;
		lo_word   = '0;
		data_word = {req_data[7:0], req_data[15:8]};
		wait_rdy  = 1'b0;
		case (state)
			ST_VDP1_VRAM, ST_VRAM: begin
				if (state == ST_VDP1_VRAM) begin
					target = vdp_bus_pkg::sel_vdp1;
				end
				hi_word  = {13'd0, req_addr.vram_view.page};
				lo_word  = {req_addr.vram_view.offset, 1'b0};
				wait_rdy = 1'b1;
			end
			ST_REG: begin
				hi_word = vdp_bus_pkg::REG_HI;
				lo_word = {req_addr.tbl_view.index, 1'b0};
			end
			ST_PAL: begin
				hi_word = vdp_bus_pkg::PAL_HI;
				lo_word = {pal_idx, 1'b0};
			end
			ST_DISP_ON: begin
				// display enable bit in the first register
				hi_word   = vdp_bus_pkg::REG_HI;
				data_word = vdp_bus_pkg::DISP_ON;
			end
			default: begin
			end
		endcase
	end

	// download word held for the whole bus cycle
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			req_addr <= dl_addr;
			req_data <= dl_data;
		end
	end

	////////////////////
	// section sequencer
	always_ff @(posedge clk_sys) begin
		start <= 1'b0;
		if (rst) begin
			state     <= ST_IDLE;
			rst_cnt   <= 2'd0;
			img_vdp1  <= 1'b0;
			busy      <= 1'b0;
			dl_wait   <= 1'b0;
			vdp_rst_n <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					if (dl_active) begin
						// only a VDP2 image resets the processors
						img_vdp1  <= dl_index0;
						vdp_rst_n <= dl_index0;
						dl_wait   <= 1'b1;
						rst_cnt   <= 2'd0;
						state     <= ST_RESET;
					end
				end
				ST_RESET: begin
					rst_cnt <= rst_cnt + 2'd1;
					if (rst_cnt == vdp_bus_pkg::RST_CYCLES) begin
						vdp_rst_n <= 1'b1;
						dl_wait   <= 1'b0;
						state     <= img_vdp1 ? ST_VDP1_VRAM : ST_VRAM;
					end
				end
				ST_VDP1_VRAM, ST_VRAM, ST_REG, ST_PAL: begin
					if (accept) begin
						start   <= 1'b1;
						busy    <= 1'b1;
						dl_wait <= 1'b1;
					end else if (done) begin
						busy    <= 1'b0;
						dl_wait <= 1'b0;
						if (req_addr == sect_last) begin
							state <= sect_next;
						end
					end
				end
				ST_DISP_ON: begin
					// one closing write, no download word behind it
					if (!busy) begin
						start <= 1'b1;
						busy  <= 1'b1;
					end else if (done) begin
						busy  <= 1'b0;
						state <= ST_END;
					end
				end
				default: begin
					if (!dl_active) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: verilog/vdp_bus_cycle.sv
// VDP bus engine: clock-enable divider and four-step parallel bus write cycle
module vdp_bus_cycle (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   start,
	input  vdp_bus_pkg::vdp_sel_e  target,
	input  vdp_bus_pkg::bus_word_t hi_word,
	input  vdp_bus_pkg::bus_word_t lo_word,
	input  vdp_bus_pkg::bus_word_t data_word,
	input  logic                   wait_rdy,
	input  logic                   vdp_rdy1_n,
	input  logic                   vdp_rdy2_n,
	output logic                   done,
	output logic                   ce_r,
	output vdp_bus_pkg::bus_word_t vdp_d,
	output logic                   vdp_ad_n,
	output logic                   vdp_dten_n,
	output logic                   vdp_cs1_n,
	output logic                   vdp_cs2_n,
	output logic                   vdp_we_n
);

	logic       active;
	logic [1:0] step;
	logic       rdy_n;
	logic       release_ok;

	// ready line of the addressed processor
	assign rdy_n = (target == vdp_bus_pkg::sel_vdp1) ? vdp_rdy1_n : vdp_rdy2_n;
	assign release_ok = !wait_rdy || !rdy_n;

	// half-rate enable shared with the VDPs
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ce_r <= 1'b0;
		end else begin
			ce_r <= ~ce_r;
		end
	end

	////////////////////
	// write cycle, one step per enable
	always_ff @(posedge clk_sys) begin
		done <= 1'b0;
		if (rst) begin
			active     <= 1'b0;
			step       <= 2'd0;
			vdp_d      <= '0;
			vdp_ad_n   <= 1'b1;
			vdp_dten_n <= 1'b1;
			vdp_cs1_n  <= 1'b1;
			vdp_cs2_n  <= 1'b1;
			vdp_we_n   <= 1'b1;
		end else if (start) begin
			active <= 1'b1;
			step   <= 2'd0;
		end else if (active && ce_r) begin
			case (step)
				2'd0: begin
					// address high word, chip selected
					vdp_d     <= hi_word;
					vdp_cs1_n <= (target != vdp_bus_pkg::sel_vdp1);
					vdp_cs2_n <= (target != vdp_bus_pkg::sel_vdp2);
					vdp_we_n  <= 1'b0;
					step      <= 2'd1;
				end
				2'd1: begin
					vdp_d <= lo_word;
					step  <= 2'd2;
				end
				2'd2: begin
					vdp_d      <= data_word;
					vdp_ad_n   <= 1'b0;
					vdp_dten_n <= 1'b0;
					step       <= 2'd3;
				end
				default: begin
					// VRAM writes hold here until the target is ready
					if (release_ok) begin
						vdp_d      <= '0;
						vdp_ad_n   <= 1'b1;
						vdp_dten_n <= 1'b1;
						vdp_cs1_n  <= 1'b1;
						vdp_cs2_n  <= 1'b1;
						vdp_we_n   <= 1'b1;
						step       <= 2'd0;
						active     <= 1'b0;
						done       <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

// File: verilog/video_mode_ctrl.sv
// video mode control: aspect ratio, scanline level and delayed mode-change toggle
module video_mode_ctrl #(
	parameter logic [31:0] VMODE_DELAY = 32'd5000000
) (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 busy,
	input  video_cfg_pkg::res_e  res,
	input  logic                 status_wide,
	input  logic                 status_corrected,
	input  logic [2:0]           scale,
	input  logic                 pal,
	output logic [7:0]           aspect_x,
	output logic [7:0]           aspect_y,
	output logic [1:0]           vga_sl,
	output logic                 vmode_toggle
);

	video_cfg_pkg::aspect_t ar;
	logic [2:0]             sl;
	logic [31:0]            vmode_cnt;
	logic                   old_pal;

	////////////////////
	// aspect ratio
	always_comb begin
		if (status_wide) begin
			ar = video_cfg_pkg::AR_WIDE;
		end else begin
			case (res)
				video_cfg_pkg::res_256_224: begin
					ar = video_cfg_pkg::AR_256_224;
				end
				video_cfg_pkg::res_320_224: begin
					ar = status_corrected ? video_cfg_pkg::AR_320_224_C :
						video_cfg_pkg::AR_256_224;
				end
				video_cfg_pkg::res_256_240: begin
					ar = video_cfg_pkg::AR_256_240;
				end
				default: begin
					ar = status_corrected ? video_cfg_pkg::AR_320_240_C :
						video_cfg_pkg::AR_256_240;
				end
			endcase
		end
	end

	assign aspect_x = ar[15:8];
	assign aspect_y = ar[7:0];

	// scale 0 means no scanlines
	assign sl = (scale != 3'd0) ? scale - 3'd1 : 3'd0;
	assign vga_sl = sl[1:0];

	////////////////////
	// mode change countdown
	always_ff @(posedge clk_sys) begin
		old_pal <= pal;
		if (rst || busy) begin
			vmode_cnt <= VMODE_DELAY;
		end else if (old_pal != pal) begin
			vmode_cnt <= VMODE_DELAY;
		end else if (vmode_cnt != 32'd0) begin
			vmode_cnt <= vmode_cnt - 32'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			vmode_toggle <= 1'b0;
		end else if (vmode_cnt == 32'd1) begin
			vmode_toggle <= ~vmode_toggle;
		end
	end

endmodule

// File: verilog/layer_debug_keys.sv
// layer debug keys: function key presses toggle the screen layer enables
module layer_debug_keys (
	input  logic                                clk_sys,
	input  logic                                rst,
	input  video_cfg_pkg::key_evt_t             key_evt,
	output logic [video_cfg_pkg::NUM_LAYERS-1:0] layer_en
);

	logic                                old_toggle;
	logic                                new_press;
	logic [video_cfg_pkg::NUM_LAYERS-1:0] flip;

	// a fresh event flips the toggle bit
	assign new_press = (key_evt[10] != old_toggle) && key_evt[9];

	always_comb begin
		flip = '0;
		case (key_evt[8:0])
			video_cfg_pkg::KEY_F1: flip[0] = 1'b1;
			video_cfg_pkg::KEY_F2: flip[1] = 1'b1;
			video_cfg_pkg::KEY_F3: flip[2] = 1'b1;
			video_cfg_pkg::KEY_F4: flip[3] = 1'b1;
			video_cfg_pkg::KEY_F5: flip[4] = 1'b1;
			video_cfg_pkg::KEY_F6: flip[5] = 1'b1;
			default: flip = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		old_toggle <= key_evt[10];
		if (rst) begin
			layer_en <= '1;
		end else if (new_press) begin
			layer_en <= layer_en ^ flip;
		end
	end

endmodule

// File: verilog/saturn_loader_top.sv
// saturn loader top: state loader, VDP bus engine, video mode control and debug keys
module saturn_loader_top #(
	parameter logic [31:0] VMODE_DELAY = 32'd5000000
) (
	input  logic                   clk_sys,
	input  logic                   rst,
	// download stream
	input  logic                   dl_active,
	input  logic                   dl_index0,
	input  logic                   dl_wr,
	input  vdp_bus_pkg::dl_addr_u  dl_addr,
	input  vdp_bus_pkg::dl_data_t  dl_data,
	output logic                   dl_wait,
	// VDP parallel bus
	output vdp_bus_pkg::bus_word_t vdp_d,
	output logic                   vdp_ad_n,
	output logic                   vdp_dten_n,
	output logic                   vdp_cs1_n,
	output logic                   vdp_cs2_n,
	output logic                   vdp_we_n,
	output logic                   vdp_rst_n,
	output logic                   ce_r,
	input  logic                   vdp_rdy1_n,
	input  logic                   vdp_rdy2_n,
	// video settings
	input  logic                   status_wide,
	input  logic                   status_corrected,
	input  video_cfg_pkg::res_e    res,
	input  logic [2:0]             scale,
	input  logic                   pal,
	input  video_cfg_pkg::key_evt_t key_evt,
	output logic [7:0]             aspect_x,
	output logic [7:0]             aspect_y,
	output logic [1:0]             vga_sl,
	output logic                   vmode_toggle,
	output logic [5:0]             layer_en,
	output logic                   loading
);

	logic                   start;
	logic                   done;
	logic                   wait_rdy;
	vdp_bus_pkg::vdp_sel_e  target;
	vdp_bus_pkg::bus_word_t hi_word;
	vdp_bus_pkg::bus_word_t lo_word;
	vdp_bus_pkg::bus_word_t data_word;

	// activity light follows the download
	assign loading = dl_active;

	state_loader u_state_loader (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.dl_active(dl_active),
		.dl_index0(dl_index0),
		.dl_wr    (dl_wr),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.done     (done),
		.dl_wait  (dl_wait),
		.vdp_rst_n(vdp_rst_n),
		.start    (start),
		.target   (target),
		.hi_word  (hi_word),
		.lo_word  (lo_word),
		.data_word(data_word),
		.wait_rdy (wait_rdy)
	);

	vdp_bus_cycle u_vdp_bus_cycle (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.start     (start),
		.target    (target),
		.hi_word   (hi_word),
		.lo_word   (lo_word),
		.data_word (data_word),
		.wait_rdy  (wait_rdy),
		.vdp_rdy1_n(vdp_rdy1_n),
		.vdp_rdy2_n(vdp_rdy2_n),
		.done      (done),
		.ce_r      (ce_r),
		.vdp_d     (vdp_d),
		.vdp_ad_n  (vdp_ad_n),
		.vdp_dten_n(vdp_dten_n),
		.vdp_cs1_n (vdp_cs1_n),
		.vdp_cs2_n (vdp_cs2_n),
		.vdp_we_n  (vdp_we_n)
	);

	video_mode_ctrl #(
		.VMODE_DELAY(VMODE_DELAY)
	) u_video_mode_ctrl (
		.clk_sys         (clk_sys),
		.rst             (rst),
		.busy            (dl_active),
		.res             (res),
		.status_wide     (status_wide),
		.status_corrected(status_corrected),
		.scale           (scale),
		.pal             (pal),
		.aspect_x        (aspect_x),
		.aspect_y        (aspect_y),
		.vga_sl          (vga_sl),
		.vmode_toggle    (vmode_toggle)
	);

	layer_debug_keys u_layer_debug_keys (
		.clk_sys (clk_sys),
		.rst     (rst),
		.key_evt (key_evt),
		.layer_en(layer_en)
	);

endmodule

// File: tb/tb_saturn_loader.sv
// saturn loader testbench: image replay, VDP bus writes, video control and debug keys
module tb_saturn_loader;

	localparam int VMODE_DELAY = 20;
	localparam int VDP1_WORDS  = 12;
	localparam int VRAM_WORDS  = 8;
	localparam int REG_WORDS   = 6;
	localparam int PAL_WORDS   = 6;
	// one extra slot for the closing display-on write
	localparam int TOTAL_WORDS = VDP1_WORDS + VRAM_WORDS + REG_WORDS + PAL_WORDS + 1;
	localparam int CYCLE_LIMIT = 40 * TOTAL_WORDS + 2000;

	// image sections as the reference sees them
	localparam int SEC_VDP1 = 0;
	localparam int SEC_VRAM = 1;
	localparam int SEC_REG  = 2;
	localparam int SEC_PAL  = 3;
	localparam int SEC_DISP = 4;

	typedef struct packed {
		vdp_bus_pkg::vdp_sel_e  sel;
		vdp_bus_pkg::bus_word_t hi;
		vdp_bus_pkg::bus_word_t lo;
		vdp_bus_pkg::bus_word_t data;
	} bus_wr_t;

	logic                    clk_sys = 1'b0;
	logic                    rst;
	logic                    dl_active;
	logic                    dl_index0;
	logic                    dl_wr;
	vdp_bus_pkg::dl_addr_u   dl_addr;
	vdp_bus_pkg::dl_data_t   dl_data;
	logic                    dl_wait;
	vdp_bus_pkg::bus_word_t  vdp_d;
	logic                    vdp_ad_n;
	logic                    vdp_dten_n;
	logic                    vdp_cs1_n;
	logic                    vdp_cs2_n;
	logic                    vdp_we_n;
	logic                    vdp_rst_n;
	logic                    ce_r;
	logic                    vdp_rdy1_n = 1'b1;
	logic                    vdp_rdy2_n = 1'b1;
	logic                    status_wide;
	logic                    status_corrected;
	video_cfg_pkg::res_e     res;
	logic [2:0]              scale;
	logic                    pal;
	video_cfg_pkg::key_evt_t key_evt;
	logic [7:0]              aspect_x;
	logic [7:0]              aspect_y;
	logic [1:0]              vga_sl;
	logic                    vmode_toggle;
	logic [5:0]              layer_en;
	logic                    loading;

	integer                  seed = 32'h5b8c_ce14;
	string                   test_name = "startup";
	logic [18:0]             stim_addr [TOTAL_WORDS];
	vdp_bus_pkg::dl_data_t   stim_data [TOTAL_WORDS];
	int                      stim_sec [TOTAL_WORDS];
	logic [1:0]              rdy_delay [TOTAL_WORDS];
	bus_wr_t                 exp_q [$];
	bus_wr_t                 act_q [$];
	bus_wr_t                 cur_wr;
	bus_wr_t                 got_wr;
	bus_wr_t                 want_wr;
	int                      bus_phase = 0;
	int                      wr_count = 0;
	int                      issued = 0;
	int                      rdy_wait;
	logic                    rdy_armed;
	int                      rst_low_cycles = 0;
	logic                    watch_no_rst = 1'b0;
	int                      cycles = 0;

	saturn_loader_top #(
		.VMODE_DELAY(32'(VMODE_DELAY))
	) dut_i (
		.clk_sys         (clk_sys),
		.rst             (rst),
		.dl_active       (dl_active),
		.dl_index0       (dl_index0),
		.dl_wr           (dl_wr),
		.dl_addr         (dl_addr),
		.dl_data         (dl_data),
		.dl_wait         (dl_wait),
		.vdp_d           (vdp_d),
		.vdp_ad_n        (vdp_ad_n),
		.vdp_dten_n      (vdp_dten_n),
		.vdp_cs1_n       (vdp_cs1_n),
		.vdp_cs2_n       (vdp_cs2_n),
		.vdp_we_n        (vdp_we_n),
		.vdp_rst_n       (vdp_rst_n),
		.ce_r            (ce_r),
		.vdp_rdy1_n      (vdp_rdy1_n),
		.vdp_rdy2_n      (vdp_rdy2_n),
		.status_wide     (status_wide),
		.status_corrected(status_corrected),
		.res             (res),
		.scale           (scale),
		.pal             (pal),
		.key_evt         (key_evt),
		.aspect_x        (aspect_x),
		.aspect_y        (aspect_y),
		.vga_sl          (vga_sl),
		.vmode_toggle    (vmode_toggle),
		.layer_en        (layer_en),
		.loading         (loading)
	);

	always #4 clk_sys = ~clk_sys;

	////////////////////
	// failure reporting and compares

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_bus_word(input string what, input vdp_bus_pkg::bus_word_t exp,
		input vdp_bus_pkg::bus_word_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
		end
	endtask

	task automatic check_aspect(input string what, input video_cfg_pkg::aspect_t exp,
		input video_cfg_pkg::aspect_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s %s expected %b actual %b", test_name, what, exp, act));
		end
	endtask

	task automatic check_level(input string what, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
		end
	endtask

	task automatic check_layers(input string what, input logic [5:0] exp, input logic [5:0] act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s %s expected %b actual %b", test_name, what, exp, act));
		end
	endtask

	////////////////////
	// reference model

	// one bus write per download word, by section
	function automatic bus_wr_t expect_write(input int sec, input logic [18:0] addr,
		input vdp_bus_pkg::dl_data_t data);
		vdp_bus_pkg::dl_addr_u a;
		bus_wr_t               w;
		a      = addr;
		w.sel  = (sec == SEC_VDP1) ? vdp_bus_pkg::sel_vdp1 : vdp_bus_pkg::sel_vdp2;
		w.data = {data[7:0], data[15:8]};
		case (sec)
			SEC_VDP1, SEC_VRAM: begin
				w.hi = 16'(a.vram_view.page);
				w.lo = 16'(a.vram_view.offset) * 16'd2;
			end
			SEC_REG: begin
				w.hi = vdp_bus_pkg::REG_HI;
				w.lo = 16'(a.tbl_view.index) * 16'd2;
			end
			SEC_PAL: begin
				w.hi = vdp_bus_pkg::PAL_HI;
				w.lo = (16'(a.tbl_view.index) - 16'(vdp_bus_pkg::PAL_BASE)) * 16'd2;
			end
			default: begin
				w.hi   = vdp_bus_pkg::REG_HI;
				w.lo   = 16'h0000;
				w.data = vdp_bus_pkg::DISP_ON;
			end
		endcase
		return w;
	endfunction

	function automatic video_cfg_pkg::aspect_t expect_aspect(input logic [1:0] r,
		input logic wide, input logic corr);
		if (wide) begin
			return video_cfg_pkg::AR_WIDE;
		end
		// bit 1 is V30, bit 0 is H40
		if (r[1]) begin
			return (r[0] && corr) ? video_cfg_pkg::AR_320_240_C : video_cfg_pkg::AR_256_240;
		end
		return (r[0] && corr) ? video_cfg_pkg::AR_320_224_C : video_cfg_pkg::AR_256_224;
	endfunction

	// scanline level per scale setting, scale 0 and 1 give none
	function automatic logic [1:0] expect_level(input logic [2:0] s);
		case (s)
			3'd2, 3'd6: return 2'd1;
			3'd3, 3'd7: return 2'd2;
			3'd4: return 2'd3;
			default: return 2'd0;
		endcase
	endfunction

	function automatic logic [8:0] key_code(input int k);
		case (k)
			0: return video_cfg_pkg::KEY_F1;
			1: return video_cfg_pkg::KEY_F2;
			2: return video_cfg_pkg::KEY_F3;
			3: return video_cfg_pkg::KEY_F4;
			4: return video_cfg_pkg::KEY_F5;
			default: return video_cfg_pkg::KEY_F6;
		endcase
	endfunction

	function automatic logic [18:0] random_vram_addr();
		// stays below VRAM_LAST so the section does not end early
		return 19'($unsigned($random(seed)) % 32'h3FFFF);
	endfunction

	task automatic build_stimulus();
		int n;
		int i;
		n = 0;
		for (i = 0; i < VDP1_WORDS; i++) begin
			stim_sec[n]  = SEC_VDP1;
			stim_addr[n] = (i == VDP1_WORDS - 1) ? vdp_bus_pkg::VRAM_LAST : random_vram_addr();
			n++;
		end
		for (i = 0; i < VRAM_WORDS; i++) begin
			stim_sec[n]  = SEC_VRAM;
			stim_addr[n] = (i == VRAM_WORDS - 1) ? vdp_bus_pkg::VRAM_LAST : random_vram_addr();
			n++;
		end
		for (i = 0; i < REG_WORDS; i++) begin
			stim_sec[n]  = SEC_REG;
			stim_addr[n] = (i == REG_WORDS - 1) ? vdp_bus_pkg::REG_LAST :
				19'h40000 + 19'($unsigned($random(seed)) % 32'd255);
			n++;
		end
		for (i = 0; i < PAL_WORDS; i++) begin
			stim_sec[n]  = SEC_PAL;
			stim_addr[n] = (i == PAL_WORDS - 1) ? vdp_bus_pkg::PAL_LAST :
				19'h40100 + 19'($unsigned($random(seed)) % 32'h7FF);
			n++;
		end
		stim_sec[n]  = SEC_DISP;
		stim_addr[n] = '0;
		for (i = 0; i < TOTAL_WORDS; i++) begin
			stim_data[i] = 16'($random(seed));
			rdy_delay[i] = 2'($random(seed));
		end
	endtask

	////////////////////
	// VDP bus slave

	// bus steps land on edges after which ce_r reads low
	always @(negedge clk_sys) begin
		if (vdp_rst_n === 1'b0) begin
			rst_low_cycles++;
			if (watch_no_rst) begin
				abort_run("vdp_rst_n went low while a VDP1 image was loading");
			end
		end
		if (vdp_cs1_n && vdp_cs2_n) begin
			bus_phase = 0;
		end else if (!ce_r) begin
			case (bus_phase)
				0: begin
					if (vdp_we_n !== 1'b0) begin
						abort_run("chip select went low without the write strobe");
					end
					check_bit("vdp_ad_n in address phase", 1'b1, vdp_ad_n);
					cur_wr.sel = vdp_cs1_n ? vdp_bus_pkg::sel_vdp2 : vdp_bus_pkg::sel_vdp1;
					cur_wr.hi  = vdp_d;
					bus_phase  = 1;
				end
				1: begin
					cur_wr.lo = vdp_d;
					bus_phase = 2;
				end
				2: begin
					if (!vdp_dten_n) begin
						check_bit("vdp_ad_n in data phase", 1'b0, vdp_ad_n);
						cur_wr.data = vdp_d;
						act_q.push_back(cur_wr);
						wr_count++;
						bus_phase = 3;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// ready answer after 0 to 3 ce periods of data phase
	always @(posedge clk_sys) begin
		if (rst || vdp_dten_n) begin
			vdp_rdy1_n <= 1'b1;
			vdp_rdy2_n <= 1'b1;
			rdy_armed  <= 1'b0;
		end else if (!rdy_armed) begin
			rdy_armed <= 1'b1;
			rdy_wait  <= 2 * int'(rdy_delay[(wr_count - 1) % TOTAL_WORDS]);
		end else if (rdy_wait != 0) begin
			rdy_wait <= rdy_wait - 1;
		end else begin
			vdp_rdy1_n <= vdp_cs1_n;
			vdp_rdy2_n <= vdp_cs2_n;
		end
	end

	// recorded writes against the reference, in order
	always @(posedge clk_sys) begin
		if (act_q.size() != 0) begin
			got_wr = act_q.pop_front();
			if (exp_q.size() == 0) begin
				abort_run("a bus write appeared that no download word asked for");
			end
			want_wr = exp_q.pop_front();
			check_bit("chip select", want_wr.sel, got_wr.sel);
			check_bus_word("high word", want_wr.hi, got_wr.hi);
			check_bus_word("low word", want_wr.lo, got_wr.lo);
			check_bus_word("data word", want_wr.data, got_wr.data);
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			abort_run($sformatf("run timed out after %0d cycles", cycles));
		end
	end

	////////////////////
	// download driver

	task automatic start_image(input logic vdp1);
		@(posedge clk_sys);
		dl_index0 <= vdp1;
		dl_active <= 1'b1;
		@(negedge clk_sys);
		check_bit("loading", 1'b1, loading);
		while (!dl_wait) begin
			@(negedge clk_sys);
		end
		// reset phase over once dl_wait drops
		while (dl_wait) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic send_word(input int idx);
		@(posedge clk_sys);
		dl_wr   <= 1'b1;
		dl_addr <= stim_addr[idx];
		dl_data <= stim_data[idx];
		exp_q.push_back(expect_write(stim_sec[idx], stim_addr[idx], stim_data[idx]));
		issued++;
		@(posedge clk_sys);
		dl_wr   <= 1'b0;
		dl_data <= ~stim_data[idx];
		@(negedge clk_sys);
		check_bit("dl_wait after dl_wr", 1'b1, dl_wait);
		while (dl_wait) begin
			@(negedge clk_sys);
		end
		if (wr_count != issued) begin
			abort_run("dl_wait dropped before the bus write was seen");
		end
		check_bit("data phase over at dl_wait fall", 1'b1, vdp_dten_n);
	endtask

	task automatic end_image();
		while (wr_count != issued) begin
			@(negedge clk_sys);
		end
		while (!vdp_dten_n || !vdp_cs1_n || !vdp_cs2_n) begin
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_bit("loading", 1'b0, loading);
		if (exp_q.size() != 0) begin
			abort_run("an expected bus write never appeared on the bus");
		end
	endtask

	task automatic press_key(input logic tog, input logic pressed, input logic [8:0] code);
		@(posedge clk_sys);
		key_evt <= {tog, pressed, code};
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	////////////////////
	// test sequence
	initial begin
		int         i;
		int         r;
		int         w;
		int         c;
		int         k;
		int         flips;
		int         rst_before;
		logic       ce_prev;
		logic       tog_start;
		logic       tog_seen;
		logic       key_tog;
		logic [5:0] exp_layers;

		rst              <= 1'b1;
		dl_active        <= 1'b0;
		dl_index0        <= 1'b0;
		dl_wr            <= 1'b0;
		dl_addr          <= '0;
		dl_data          <= '0;
		status_wide      <= 1'b0;
		status_corrected <= 1'b0;
		res              <= video_cfg_pkg::res_256_224;
		scale            <= 3'd0;
		pal              <= 1'b0;
		key_evt          <= '0;
		build_stimulus();
		repeat (8) @(posedge clk_sys);
		rst <= 1'b0;

		test_name = "reset state";
		@(negedge clk_sys);
		check_bit("dl_wait", 1'b0, dl_wait);
		check_bit("vdp_cs1_n", 1'b1, vdp_cs1_n);
		check_bit("vdp_cs2_n", 1'b1, vdp_cs2_n);
		check_bit("vdp_dten_n", 1'b1, vdp_dten_n);
		check_bit("vdp_ad_n", 1'b1, vdp_ad_n);
		check_bit("vdp_we_n", 1'b1, vdp_we_n);
		check_bit("vdp_rst_n", 1'b1, vdp_rst_n);
		check_bus_word("vdp_d", 16'h0000, vdp_d);
		check_layers("layer_en", 6'h3F, layer_en);
		check_bit("vmode_toggle", 1'b0, vmode_toggle);
		check_bit("loading", 1'b0, loading);
		// ce divider flips on every clock
		ce_prev = ce_r;
		@(negedge clk_sys);
		check_bit("ce_r toggles", ~ce_prev, ce_r);

		test_name    = "vdp1 image";
		watch_no_rst = 1'b1;
		start_image(1'b1);
		for (i = 0; i < VDP1_WORDS; i++) begin
			send_word(i);
		end
		end_image();
		watch_no_rst = 1'b0;

		test_name  = "vdp2 image";
		rst_before = rst_low_cycles;
		start_image(1'b0);
		check_bit("vdp reset pulse seen", 1'b1, rst_low_cycles > rst_before);
		for (i = VDP1_WORDS; i < TOTAL_WORDS - 1; i++) begin
			send_word(i);
		end
		exp_q.push_back(expect_write(SEC_DISP, '0, '0));
		issued++;
		end_image();

		test_name = "aspect";
		for (r = 0; r < 4; r++) begin
			for (w = 0; w < 2; w++) begin
				for (c = 0; c < 2; c++) begin
					@(posedge clk_sys);
					res              <= video_cfg_pkg::res_e'(r);
					status_wide      <= w[0];
					status_corrected <= c[0];
					@(negedge clk_sys);
					check_aspect("aspect pair", expect_aspect(2'(r), w[0], c[0]),
						{aspect_x, aspect_y});
				end
			end
		end

		test_name = "scanlines";
		for (i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			scale <= 3'(i);
			@(negedge clk_sys);
			check_level("vga_sl", expect_level(3'(i)), vga_sl);
		end

		// let the countdown left by the last download run out first
		test_name = "vmode toggle";
		repeat (VMODE_DELAY + 4) @(posedge clk_sys);
		@(negedge clk_sys);
		tog_start = vmode_toggle;
		tog_seen  = tog_start;
		flips     = 0;
		@(posedge clk_sys);
		pal <= ~pal;
		for (i = 0; i < 3 * VMODE_DELAY + 2; i++) begin
			@(negedge clk_sys);
			if (vmode_toggle != tog_seen) begin
				flips++;
				tog_seen = vmode_toggle;
			end
			if (i == VMODE_DELAY + 1) begin
				check_bit("toggle after pal change", ~tog_start, vmode_toggle);
			end
		end
		check_bit("exactly one flip", 1'b1, flips == 1);

		test_name  = "layer keys";
		exp_layers = 6'h3F;
		key_tog    = 1'b0;
		for (k = 0; k < 6; k++) begin
			key_tog = ~key_tog;
			press_key(key_tog, 1'b1, key_code(k));
			exp_layers[k] = ~exp_layers[k];
			check_layers("after function key", exp_layers, layer_en);
			// same event again, toggle unchanged
			press_key(key_tog, 1'b1, key_code(k));
			check_layers("repeated event", exp_layers, layer_en);
		end
		key_tog = ~key_tog;
		press_key(key_tog, 1'b1, 9'h01C);
		check_layers("unlisted scan code", exp_layers, layer_en);
		key_tog = ~key_tog;
		press_key(key_tog, 1'b0, video_cfg_pkg::KEY_F1);
		check_layers("key release", exp_layers, layer_en);

		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: sources.f
verilog/vdp_bus_pkg.sv
verilog/video_cfg_pkg.sv
verilog/state_loader.sv
verilog/vdp_bus_cycle.sv
verilog/video_mode_ctrl.sv
verilog/layer_debug_keys.sv
verilog/saturn_loader_top.sv
tb/tb_saturn_loader.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_saturn_loader -f sources.f
out=$(./obj_dir/Vtb_saturn_loader 2>&1 || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "Finished with no errors"; then
	exit 0
fi
exit 1
